/* verilog/pal_settings.svh */
// PAL line and field timing in clk24 cycles, plus DAC output levels.
// Line length assumes the 24 MHz pixel clock; other clocks need new values.

`ifndef PAL_SETTINGS_SVH
`define PAL_SETTINGS_SVH

// line and half-line lengths
`define PAL_LINE_LEN      1536
`define PAL_HALF_LEN      768

// sync pulse widths
`define PAL_HSYNC_LEN     114
`define PAL_NARROW_LEN    56
`define PAL_BROAD_LEN     655

// blanking and burst windows, in line clocks
`define PAL_BLANK_START   1496
`define PAL_BLANK_END     249
`define PAL_BURST_START   139
`define PAL_BURST_END     212

// half-line numbers of the vertical sync region
`define PAL_BROAD_LAST    4
`define PAL_NARROW_LAST   9
`define PAL_NARROW_FIRST  618

// output levels
`define PAL_V_SYNC        0
`define PAL_V_REF         8
`define PAL_CHROMA_ZERO   16

`endif

/* verilog/pal_pkg.sv */
// Shared types of the PAL encoder.
// The timing bundle is produced once per clock by pal_timing.

`default_nettype none

package pal_pkg;

    // expanded palette colour, 4 bits per component
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb4_t;

    typedef struct packed {
        logic       halfline_odd;   // bit 1 of the half-line count
        logic       field_odd;
        logic       sync_n;         // composite sync, active low
        logic       blank;
        logic       burst;
        logic       field_zone;     // vertical sync region
        logic [7:0] spare;          // reserved, driven low
    } tv_timing_t;

    // output source picked by the mixer
    typedef enum logic [1:0] {
        OUT_SYNC,
        OUT_BURST,
        OUT_BLANK,
        OUT_ACTIVE
    } out_sel_e;

    typedef struct packed {
        logic [7:0] cvbs;
        logic [7:0] luma;
        logic [7:0] chroma;
    } tv_out_t;

endpackage

`default_nettype wire

/* verilog/pal_timing.sv */
// Line and field timing for one PAL field, restarted by the vsync_i fall.
// Without a vsync_i fall the half-line count runs on and wraps at 1024.
// blank and burst lag the counters by one clock, sync_n does not.

`timescale 1ns/100ps
`default_nettype none

`include "pal_settings.svh"

module pal_timing (
    input  wire                 clk24,
    input  wire                 arst_n_i,
    input  wire                 vsync_i,
    output pal_pkg::tv_timing_t timing_o
);

    logic        vsync_q;
    logic        vs_fall_q;
    logic [10:0] line_clk_q;
    logic [9:0]  half_clk_q;
    logic [9:0]  halfline_q;
    logic        field_q;
    logic        blank_q;
    logic        burst_q;
    logic        sync_n;
    logic        field_zone;

    // --------------------------------------------------
    // counters
    // --------------------------------------------------
    always_ff @(posedge clk24 or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vsync_q    <= 1'b1;
            vs_fall_q  <= 1'b0;
            line_clk_q <= '0;
            half_clk_q <= '0;
            halfline_q <= '0;
            field_q    <= 1'b0;
            blank_q    <= 1'b1;
            burst_q    <= 1'b0;
        end else begin
            vsync_q   <= vsync_i;
            vs_fall_q <= vsync_q & ~vsync_i;

            if (vs_fall_q) begin
                // new field, all counters restart together
                line_clk_q <= '0;
                half_clk_q <= '0;
                halfline_q <= '0;
                field_q    <= ~field_q;
            end else begin
                if (line_clk_q == 11'(`PAL_LINE_LEN - 1))
                    line_clk_q <= '0;
                else
                    line_clk_q <= line_clk_q + 11'd1;

                if (half_clk_q == 10'(`PAL_HALF_LEN - 1)) begin
                    half_clk_q <= '0;
                    halfline_q <= halfline_q + 10'd1;
                end else begin
                    half_clk_q <= half_clk_q + 10'd1;
                end
            end

            // blank high selects OUT_BLANK, or OUT_BURST inside the burst window
            blank_q <= (line_clk_q < 11'(`PAL_BLANK_END)) ||
                       (line_clk_q > 11'(`PAL_BLANK_START)) || field_zone;
            burst_q <= (line_clk_q >= 11'(`PAL_BURST_START)) &&
                       (line_clk_q <= 11'(`PAL_BURST_END));
        end
    end

    // --------------------------------------------------
    // composite sync, low selects OUT_SYNC
    // --------------------------------------------------
    always_comb begin
        field_zone = 1'b1;
        if (halfline_q <= 10'(`PAL_BROAD_LAST)) begin
            sync_n = (half_clk_q >= 10'(`PAL_BROAD_LEN));
        end else if ((halfline_q <= 10'(`PAL_NARROW_LAST)) ||
                     (halfline_q >= 10'(`PAL_NARROW_FIRST))) begin
            // equalising pulses
            sync_n = (half_clk_q >= 10'(`PAL_NARROW_LEN));
        end else begin
            field_zone = 1'b0;
            sync_n     = (line_clk_q >= 11'(`PAL_HSYNC_LEN));
        end
    end

    always_comb begin
        timing_o.halfline_odd = halfline_q[1];
        timing_o.field_odd    = field_q;
        timing_o.sync_n       = sync_n;
        timing_o.blank        = blank_q;
        timing_o.burst        = burst_q;
        timing_o.field_zone   = field_zone;
        timing_o.spare        = '0;
    end

endmodule

`default_nettype wire

/* verilog/pal_subcarrier.sv */
// Subcarrier phase generator, stepped by fsc_ce_i at 4x the subcarrier rate.
// The two counters sit one step apart, giving the two burst phases.

`timescale 1ns/100ps
`default_nettype none

module pal_subcarrier (
    input  wire                 clk24,
    input  wire                 arst_n_i,
    input  wire                 fsc_ce_i,
    input  wire                 field_alt_en_i,
    input  wire pal_pkg::tv_timing_t timing_i,
    output logic [4:0]          phase_idx_o,
    output logic [7:0]          burst_sin_o
);

    logic [3:0] phase_q;
    logic [3:0] phase0_q;
    logic       line_par;
    logic [2:0] sin_addr;

    always_ff @(posedge clk24 or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase_q  <= 4'd0;
            phase0_q <= 4'd1;
        end else if (fsc_ce_i) begin
            phase_q  <= phase_q + 4'd1;
            phase0_q <= phase0_q + 4'd1;
        end
    end

    // line parity, optionally flipped on odd fields
    assign line_par    = timing_i.halfline_odd ^ (field_alt_en_i & timing_i.field_odd);
    assign phase_idx_o = {line_par, phase0_q};
    assign sin_addr    = line_par ? phase0_q[3:1] : phase_q[3:1];

    // sine table, 8 steps per subcarrier period
    always_comb begin
        case (sin_addr)
            3'd0:    burst_sin_o = 8'd91;
            3'd1:    burst_sin_o = 8'd0;
            3'd2:    burst_sin_o = 8'd0;
            3'd3:    burst_sin_o = 8'd91;
            3'd4:    burst_sin_o = 8'd218;
            3'd5:    burst_sin_o = 8'd255;
            3'd6:    burst_sin_o = 8'd255;
            default: burst_sin_o = 8'd218;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/pal_colour_matrix.sv */
// Palette colour to luma and modulated chroma, purely combinational.
// Palette byte is B B G G G R R R; chroma wraps for a few saturated colours.

`timescale 1ns/100ps
`default_nettype none

module pal_colour_matrix (
    input  wire [7:0]          colour_i,
    input  wire [4:0]          phase_idx_i,
    output logic [4:0]         luma_o,
    output logic signed [7:0]  chroma_o
);

    // U sin + V cos folded into one weight per component
    typedef struct packed {
        logic signed [6:0] kr;
        logic signed [6:0] kg;
        logic signed [6:0] kb;
    } uv_coef_t;

    pal_pkg::rgb4_t    rgb;
    uv_coef_t          coef;
    logic [13:0]       y_sum;
    logic signed [13:0] uv_sum;

    always_comb begin
        rgb.r = {colour_i[2:0], 1'b0};
        rgb.g = {colour_i[5:3], 1'b0};
        rgb.b = {colour_i[7:6], 2'b00};
    end

    // luma weights roughly 0.30/0.59/0.11
    assign y_sum  = rgb.r * 10'd24 + rgb.g * 10'd47 + rgb.b * 10'd9;
    assign luma_o = y_sum[10:6];

    // --------------------------------------------------
    // chroma weights, top index bit is the line parity
    // --------------------------------------------------
    always_comb begin
        case (phase_idx_i)
            5'd0:    coef = '{ 49, -41,  -7};
            5'd1:    coef = '{ 40, -46,   5};
            5'd2:    coef = '{ 26, -45,  18};
            5'd3:    coef = '{  7, -36,  29};
            5'd4:    coef = '{-11, -22,  34};
            5'd5:    coef = '{-29,  -5,  35};
            5'd6:    coef = '{-42,  12,  30};
            5'd7:    coef = '{-49,  29,  20};
            5'd8:    coef = '{-49,  41,   7};
            5'd9:    coef = '{-40,  46,  -5};
            5'd10:   coef = '{-26,  45, -18};
            5'd11:   coef = '{ -7,  36, -29};
            5'd12:   coef = '{ 11,  22, -34};
            5'd13:   coef = '{ 29,   5, -35};
            5'd14:   coef = '{ 42, -12, -30};
            5'd15:   coef = '{ 49, -29, -20};
            // V inverted on the other line
            5'd16:   coef = '{-49,  41,   7};
            5'd17:   coef = '{-49,  29,  20};
            5'd18:   coef = '{-42,  12,  30};
            5'd19:   coef = '{-29,  -5,  35};
            5'd20:   coef = '{-11, -22,  34};
            5'd21:   coef = '{  7, -36,  29};
            5'd22:   coef = '{ 26, -45,  18};
            5'd23:   coef = '{ 40, -46,   5};
            5'd24:   coef = '{ 49, -41,  -7};
            5'd25:   coef = '{ 49, -29, -20};
            5'd26:   coef = '{ 42, -12, -30};
            5'd27:   coef = '{ 29,   5, -35};
            5'd28:   coef = '{ 11,  22, -34};
            5'd29:   coef = '{ -7,  36, -29};
            5'd30:   coef = '{-26,  45, -18};
            default: coef = '{-40,  46,  -5};
        endcase
    end

    assign uv_sum = $signed(coef.kr) * $signed({4'b0000, rgb.r}) +
                    $signed(coef.kg) * $signed({4'b0000, rgb.g}) +
                    $signed(coef.kb) * $signed({4'b0000, rgb.b});

    // two scaled slices summed, between the dim and the bright scaling
    assign chroma_o = {1'b0, uv_sum[13:7]} + {1'b0, uv_sum[12:6]};

endmodule

`default_nettype wire

/* verilog/pal_mixer.sv */
// Output mixer for the CVBS, luma and chroma DACs, one clock after its inputs.
// Active levels wrap at 5 bits, so very bright colours fold over.

`timescale 1ns/100ps
`default_nettype none

`include "pal_settings.svh"

module pal_mixer (
    input  wire                      clk24,
    input  wire                      arst_n_i,
    input  wire pal_pkg::tv_timing_t timing_i,
    input  wire [4:0]                luma_i,
    input  wire signed [7:0]         chroma_i,
    input  wire [7:0]                burst_sin_i,
    output pal_pkg::tv_out_t         tv_o,
    output logic                     tv_sync_o
);

    pal_pkg::out_sel_e out_sel;
    pal_pkg::tv_out_t  tv_d;
    logic [4:0]        luma_lvl;
    logic [4:0]        chroma_step;

    always_comb begin
        if (!timing_i.sync_n)
            out_sel = pal_pkg::OUT_SYNC;
        else if (timing_i.blank && timing_i.burst)
            out_sel = pal_pkg::OUT_BURST;
        else if (timing_i.blank)
            out_sel = pal_pkg::OUT_BLANK;
        else
            out_sel = pal_pkg::OUT_ACTIVE;
    end

    assign luma_lvl    = 5'(`PAL_V_REF) + luma_i;
    // chroma scaled down by 2, sign kept
    assign chroma_step = {chroma_i[4], chroma_i[4:1]};

    always_comb begin
        case (out_sel)
            pal_pkg::OUT_SYNC: begin
                tv_d.cvbs   = 8'(`PAL_V_SYNC);
                tv_d.luma   = 8'(`PAL_V_SYNC);
                tv_d.chroma = 8'(`PAL_CHROMA_ZERO);
            end
            pal_pkg::OUT_BURST: begin
                // small swing around black on cvbs, +-4 around zero on chroma
                tv_d.cvbs   = 8'(`PAL_V_REF + 2) - {6'd0, burst_sin_i[7:6]};
                tv_d.luma   = 8'(`PAL_V_REF);
                tv_d.chroma = 8'd12 + {5'd0, burst_sin_i[7:5]};
            end
            pal_pkg::OUT_BLANK: begin
                tv_d.cvbs   = 8'(`PAL_V_REF);
                tv_d.luma   = 8'(`PAL_V_REF);
                tv_d.chroma = 8'(`PAL_CHROMA_ZERO);
            end
            default: begin
                tv_d.cvbs   = {3'd0, luma_lvl - chroma_step};
                tv_d.luma   = {3'd0, luma_lvl};
                tv_d.chroma = {3'd0, 5'(`PAL_CHROMA_ZERO) + chroma_i[4:0]};
            end
        endcase
    end

    always_ff @(posedge clk24 or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tv_o.cvbs   <= 8'(`PAL_V_REF);
            tv_o.luma   <= 8'(`PAL_V_REF);
            tv_o.chroma <= 8'(`PAL_CHROMA_ZERO);
            tv_sync_o   <= 1'b1;
        end else begin
            tv_o      <= tv_d;
            tv_sync_o <= timing_i.sync_n;
        end
    end

endmodule

`default_nettype wire

/* verilog/pal_encoder.sv */
// PAL composite encoder top, single clock domain on clk24.
// fsc_ce_i must pulse at 4x the colour subcarrier rate.
// colour_i is sampled every clock, outputs follow one clock later.

`timescale 1ns/100ps
`default_nettype none

module pal_encoder (
    input  wire              clk24,
    input  wire              arst_n_i,
    input  wire              vsync_i,
    input  wire              fsc_ce_i,
    input  wire              field_alt_en_i,
    input  wire [7:0]        colour_i,
    output pal_pkg::tv_out_t tv_o,
    output logic             tv_sync_o
);

    pal_pkg::tv_timing_t timing;
    logic [4:0]          phase_idx;
    logic [7:0]          burst_sin;
    logic [4:0]          luma;
    logic signed [7:0]   chroma;

    pal_timing i_pal_timing (
        .clk24    (clk24),
        .arst_n_i (arst_n_i),
        .vsync_i  (vsync_i),
        .timing_o (timing)
    );

    pal_subcarrier i_pal_subcarrier (
        .clk24          (clk24),
        .arst_n_i       (arst_n_i),
        .fsc_ce_i       (fsc_ce_i),
        .field_alt_en_i (field_alt_en_i),
        .timing_i       (timing),
        .phase_idx_o    (phase_idx),
        .burst_sin_o    (burst_sin)
    );

    pal_colour_matrix i_pal_colour_matrix (
        .colour_i    (colour_i),
        .phase_idx_i (phase_idx),
        .luma_o      (luma),
        .chroma_o    (chroma)
    );

    pal_mixer i_pal_mixer (
        .clk24       (clk24),
        .arst_n_i    (arst_n_i),
        .timing_i    (timing),
        .luma_i      (luma),
        .chroma_i    (chroma),
        .burst_sin_i (burst_sin),
        .tv_o        (tv_o),
        .tv_sync_o   (tv_sync_o)
    );

endmodule

`default_nettype wire

/* tb/tb_pal_encoder.sv */
// Testbench for pal_encoder covering field sync, line sync, blanking, burst and luma.
// Colours and expected levels come from tb/pal_stimulus.txt, read from the project root.
// Inputs are driven and outputs sampled on the falling clock edge.

`timescale 1ns/100ps
`default_nettype none

`include "pal_settings.svh"

module tb_pal_encoder;

    localparam int NUM_REC    = 21;
    localparam int REC_WORDS  = 5;
    localparam int RESET_CYC  = 16;
    localparam int FSC_DIV    = 6;
    localparam int MAX_CYCLES = 40 * `PAL_LINE_LEN;

    logic             clk24;
    logic             arst_n_i;
    logic             vsync_i;
    logic             fsc_ce_i;
    logic             field_alt_en_i;
    logic [7:0]       colour_i;
    pal_pkg::tv_out_t tv_o;
    logic             tv_sync_o;

    // each record holds kind, colour, luma, cvbs and chroma as hex words
    logic [7:0] stim_mem [0:NUM_REC*REC_WORDS-1];
    int         tick = 0;
    int         fall_tick = 0;
    int         fsc_cnt = 0;
    int         cycle_cnt = 0;

    pal_encoder i_pal_encoder (
        .clk24          (clk24),
        .arst_n_i       (arst_n_i),
        .vsync_i        (vsync_i),
        .fsc_ce_i       (fsc_ce_i),
        .field_alt_en_i (field_alt_en_i),
        .colour_i       (colour_i),
        .tv_o           (tv_o),
        .tv_sync_o      (tv_sync_o)
    );

    initial begin
        clk24 = 1'b0;
        forever #4 clk24 = ~clk24;
    end

    // run limit counted from reset release
    always @(posedge clk24) begin
        if (arst_n_i === 1'b1) begin
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt > MAX_CYCLES) begin
                $display("timeout: the test did not finish within %0d clocks", MAX_CYCLES);
                $display("Test FAILED");
                $fatal(1, "simulation stopped by timeout");
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, actual,
                     expected);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // advance one clock and raise fsc_ce_i on every 6th
    task automatic next_cycle();
        @(negedge clk24);
        tick++;
        if (fsc_cnt == FSC_DIV - 1) begin
            fsc_cnt  = 0;
            fsc_ce_i = 1'b1;
        end else begin
            fsc_cnt++;
            fsc_ce_i = 1'b0;
        end
    endtask

    task automatic wait_sync_fall(output int gap);
        while (tv_sync_o !== 1'b1)
            next_cycle();
        while (tv_sync_o !== 1'b0)
            next_cycle();
        gap       = tick - fall_tick;
        fall_tick = tick;
    endtask

    // measure the current sync pulse while cvbs sits at sync level
    task automatic measure_low(output int width);
        width = 0;
        while (tv_sync_o === 1'b0) begin
            check_value("tv_o.cvbs during sync", tv_o.cvbs, `PAL_V_SYNC);
            width++;
            next_cycle();
        end
    endtask

    task automatic wait_offset(input int offset);
        while (tick - fall_tick < offset)
            next_cycle();
    endtask

    // --------------------------------------------------
    // five broad and five equalising pulses after the field start
    // --------------------------------------------------
    task automatic check_field_sync();
        int gap;
        int width;
        int start_tick;
        int p;
        vsync_i    = 1'b0;
        start_tick = tick;
        wait_sync_fall(gap);
        check_value("vsync_i fall to tv_sync_o fall", tick - start_tick, 3);
        for (p = 0; p < 10; p++) begin
            if (p > 0) begin
                wait_sync_fall(gap);
                check_value("half-line pulse spacing", gap, `PAL_HALF_LEN);
            end
            measure_low(width);
            if (p < 5)
                check_value("broad pulse width", width, `PAL_BROAD_LEN);
            else
                check_value("equalising pulse width", width, `PAL_NARROW_LEN);
            vsync_i = 1'b1;
        end
        wait_sync_fall(gap);
        check_value("first line sync spacing", gap, `PAL_HALF_LEN);
    endtask

    // checks one normal line starting at its sync fall
    task automatic check_line(input int rec);
        int         width;
        int         base;
        logic [7:0] kind;
        logic [7:0] exp_luma;
        base     = rec * REC_WORDS;
        kind     = stim_mem[base];
        exp_luma = stim_mem[base + 2];
        colour_i = stim_mem[base + 1];
        measure_low(width);
        check_value("line sync width", width, `PAL_HSYNC_LEN);

        wait_offset(170);
        check_value($sformatf("tv_o.chroma=%0d within 12..19 in burst", tv_o.chroma),
                    (tv_o.chroma >= 12) && (tv_o.chroma <= 19), 1);
        check_value($sformatf("tv_o.cvbs=%0d within 7..10 in burst", tv_o.cvbs),
                    (tv_o.cvbs >= 7) && (tv_o.cvbs <= 10), 1);
        check_value("tv_o.luma in burst", tv_o.luma, `PAL_V_REF);

        wait_offset(230);
        check_value("tv_sync_o in blanking", tv_sync_o, 1);
        check_value("tv_o.luma in blanking", tv_o.luma, `PAL_V_REF);
        check_value("tv_o.cvbs in blanking", tv_o.cvbs, `PAL_V_REF);
        check_value("tv_o.chroma in blanking", tv_o.chroma, 16);

        wait_offset(800);
        check_value("tv_o.luma", tv_o.luma, (`PAL_V_REF + exp_luma) % 32);
        if (kind == 8'h01) begin
            check_value("tv_o.cvbs for black", tv_o.cvbs, stim_mem[base + 3]);
            check_value("tv_o.chroma for black", tv_o.chroma, stim_mem[base + 4]);
        end
    endtask

    initial begin
        int gap;
        int rec;
        int black_rec;
        arst_n_i       = 1'b0;
        vsync_i        = 1'b1;
        fsc_ce_i       = 1'b0;
        field_alt_en_i = 1'b0;
        colour_i       = 8'h00;
        black_rec      = -1;
        $readmemh("tb/pal_stimulus.txt", stim_mem);
        if ($isunknown(stim_mem[NUM_REC*REC_WORDS-1])) begin
            $display("the stimulus file tb/pal_stimulus.txt is missing or too short");
            $display("Test FAILED");
            $fatal(1, "no stimulus");
        end

        repeat (RESET_CYC)
            next_cycle();
        arst_n_i = 1'b1;

        // let the first free-running broad pulse end before restarting the field
        wait_sync_fall(gap);
        while (tv_sync_o === 1'b0)
            next_cycle();
        repeat (10)
            next_cycle();
        check_field_sync();

        // move on to half-line 20
        repeat (5) begin
            wait_sync_fall(gap);
            check_value("line sync period", gap, `PAL_LINE_LEN);
        end

        for (rec = 0; rec < NUM_REC; rec++) begin
            wait_sync_fall(gap);
            check_value("line sync period", gap, `PAL_LINE_LEN);
            field_alt_en_i = rec[0];
            if (stim_mem[rec * REC_WORDS] == 8'h01)
                black_rec = rec;
            check_line(rec);
        end
        if (black_rec < 0) begin
            $display("the stimulus file holds no black-level row");
            $display("Test FAILED");
            $fatal(1, "no black-level row");
        end

        // black again on the first line of a second field with phase alternation on
        field_alt_en_i = 1'b1;
        check_field_sync();
        check_line(black_rec);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+verilog
verilog/pal_pkg.sv
verilog/pal_timing.sv
verilog/pal_subcarrier.sv
verilog/pal_colour_matrix.sv
verilog/pal_mixer.sv
verilog/pal_encoder.sv
tb/tb_pal_encoder.sv

/* tb/pal_stimulus.txt */
// columns: kind colour luma cvbs chroma, all hex, one record per video line
// kind 00 checks luma only, kind 01 is the black-level row that also checks cvbs and chroma
// luma is (24*R4 + 47*G4 + 9*B4) >> 6 of the expanded palette components
// cvbs and chroma are 00 and unused on kind 00 rows
00 07 05 00 00
00 38 0a 00 00
00 c0 01 00 00
00 ff 11 00 00
00 01 00 00 00
00 02 01 00 00
00 04 03 00 00
00 08 01 00 00
00 10 02 00 00
00 20 05 00 00
00 40 00 00 00
01 00 00 08 10
00 80 01 00 00
00 3f 0f 00 00
00 c7 06 00 00
00 f8 0b 00 00
00 92 05 00 00
00 49 02 00 00
00 b6 0e 00 00
00 6d 0b 00 00
00 24 08 00 00
